// ==== dma_cpci_top.f ====
dma_pkg.sv
dma_word_if.sv
dma_word_fifo.sv
dma_bus_fsm.sv
dma_regs.sv
dma_cpci_top.sv
tb_dma_cpci_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the cpci dma bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f dma_cpci_top.f \
	--top-module tb_dma_cpci_top -Mdir obj_dir; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/Vtb_dma_cpci_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1

// ==== tb_dma_cpci_top.sv ====
////////////////////////////////////////
// testbench for the cpci dma bridge
// clock, reset, apb/cpci/core stimulus
// tx queue scoreboard, n2c monitor
// concurrent checks and watchdog
////////////////////////////////////////

`timescale 1ns/1ps

module tb_dma_cpci_top;

	localparam int CLK_PERIOD = 100;
	localparam int N_QUERY    = 4;
	localparam int N_C2N      = 8;
	localparam int N_N2C      = 4;
	localparam int N_PKTS     = N_QUERY + N_C2N + N_N2C + 2;   // plus fill and enable-off
	localparam int NF_LEVEL   = dma_pkg::FIFO_DEPTH - dma_pkg::FIFO_NEARLY_FULL_MARGIN;

	logic                  cpci_clk;
	logic                  cpci_reset;
	dma_pkg::dma_op_t      dma_op_code_req;
	dma_pkg::queue_id_t    dma_op_queue_id;
	dma_pkg::dma_op_t      dma_op_code_ack;
	logic                  dma_vld_c2n;
	dma_pkg::dma_data_t    dma_data_c2n;
	logic                  dma_dest_q_nearly_full_n2c;
	logic                  dma_vld_n2c;
	dma_pkg::dma_data_t    dma_data_n2c;
	logic                  dma_dest_q_nearly_full_c2n;
	logic                  dma_data_tri_en;
	dma_pkg::q_mask_t      cpu_q_dma_pkt_avail;
	dma_pkg::q_mask_t      cpu_q_dma_nearly_full;
	logic                  psel, penable, pwrite;
	dma_pkg::apb_addr_t    paddr;
	dma_pkg::dma_data_t    pwdata, prdata;
	logic                  pready, pslverr;
	logic                  txq_rd, txq_empty, txq_is_req, txq_eop;
	dma_pkg::valid_bytes_t txq_valid_bytes;
	dma_pkg::dma_data_t    txq_data;
	logic                  rxq_wr, rxq_eop, rxq_full;
	dma_pkg::valid_bytes_t rxq_valid_bytes;
	dma_pkg::dma_data_t    rxq_data;

	dma_pkg::dma_word_t tx_exp[$];    // words expected out of txq
	dma_pkg::dma_data_t n2c_exp[$];   // words expected on dma_data_n2c
	int                 chk_errs;
	int                 sva_errs;
	logic               drain_en;     // pop txq while set
	logic               nf_rand_en;   // toggle cpci nearly full

	dma_cpci_top u_dut (.*);

	always #(CLK_PERIOD/2) cpci_clk = ~cpci_clk;

	////////////////////////////////////////
	// helpers
	task automatic next_cycle();
		@(posedge cpci_clk);
		#1;
	endtask

	task automatic expect_eq(input string name, input logic [35:0] got, input logic [35:0] exp);
		assert (got === exp) else begin
			chk_errs++;
			$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic apb_write(input dma_pkg::apb_addr_t a, input dma_pkg::dma_data_t d);
		psel   = 1'b1;
		pwrite = 1'b1;
		paddr  = a;
		pwdata = d;
		next_cycle();
		penable = 1'b1;   // access phase
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input dma_pkg::apb_addr_t a, output dma_pkg::dma_data_t d,
		output logic err);
		psel   = 1'b1;
		pwrite = 1'b0;
		paddr  = a;
		next_cycle();
		penable = 1'b1;
		#40;              // mid access phase
		d   = prdata;
		err = pslverr;
		expect_eq("pready", pready, 1'b1);   // no wait states
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_reg(input dma_pkg::apb_addr_t a, input dma_pkg::dma_data_t exp);
		dma_pkg::dma_data_t d;
		logic               err;
		apb_read(a, d, err);
		expect_eq("prdata", d, exp);
		expect_eq("pslverr", err, 1'b0);
	endtask

	task automatic wait_ack(input dma_pkg::dma_op_t op);
		int n;
		n = 0;
		while (dma_op_code_ack != op && n < 20) begin
			next_cycle();
			n++;
		end
		if (dma_op_code_ack != op) begin
			chk_errs++;
			$display("op code ack never reached %s", op.name());
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((tx_exp.size() != 0 || n2c_exp.size() != 0) && n < 200) begin
			next_cycle();
			n++;
		end
		if (tx_exp.size() != 0 || n2c_exp.size() != 0) begin
			chk_errs++;
			$display("expected words still pending after 200 cycles");
		end
	endtask

	task automatic run_query();
		dma_pkg::dma_data_t st;
		cpu_q_dma_pkt_avail   = dma_pkg::q_mask_t'($urandom);
		cpu_q_dma_nearly_full = dma_pkg::q_mask_t'($urandom);
		st        = '0;
		st[19:16] = cpu_q_dma_pkt_avail;
		st[3:0]   = cpu_q_dma_nearly_full;
		dma_op_code_req = dma_pkg::OP_STATUS_QUERY;
		next_cycle();
		next_cycle();
		expect_eq("dma_op_code_ack", dma_op_code_ack, dma_pkg::OP_IDLE);   // not yet
		next_cycle();
		expect_eq("dma_op_code_ack", dma_op_code_ack, dma_pkg::OP_STATUS_QUERY);
		expect_eq("dma_vld_n2c", dma_vld_n2c, 1'b1);
		expect_eq("dma_data_tri_en", dma_data_tri_en, 1'b1);
		expect_eq("dma_data_n2c", dma_data_n2c, st);
		dma_op_code_req = dma_pkg::OP_IDLE;
		repeat (4) next_cycle();
	endtask

	// host-to-card packet, expected txq words built from the length
	task automatic c2n_packet(input int len, input dma_pkg::queue_id_t qid);
		int                 nw;
		dma_pkg::dma_data_t w[$];
		logic               last;
		nw = (len + 3) / 4;
		tx_exp.push_back({1'b1, 1'b0, 2'b00, 32'(qid)});     // request, direction 0
		tx_exp.push_back({1'b0, len == 0, 2'b00, 32'(len)});
		w.push_back(32'(len));
		for (int i = 0; i < nw; i++) begin
			w.push_back($urandom);
			last = (i == nw - 1);
			tx_exp.push_back({1'b0, last, last ? 2'(len % 4) : 2'b00, w[i+1]});
		end
		dma_op_code_req = dma_pkg::OP_TRANSF_C2N;
		dma_op_queue_id = qid;
		wait_ack(dma_pkg::OP_TRANSF_C2N);
		foreach (w[i]) begin
			dma_vld_c2n  = 1'b1;
			dma_data_c2n = w[i];
			next_cycle();
		end
		dma_vld_c2n     = 1'b0;
		dma_op_code_req = dma_pkg::OP_IDLE;
		repeat (4) next_cycle();
	endtask

	// card-to-host packet, rxq preloaded first
	task automatic n2c_packet(input int len, input dma_pkg::queue_id_t qid);
		int nw;
		nw = (len + 3) / 4;
		tx_exp.push_back({1'b1, 1'b1, 2'b00, 32'(qid)});     // request, direction 1
		rxq_wr   = 1'b1;
		rxq_eop  = (len == 0);
		rxq_data = 32'(len);
		n2c_exp.push_back(rxq_data);
		next_cycle();
		for (int i = 0; i < nw; i++) begin
			rxq_eop         = (i == nw - 1);
			rxq_valid_bytes = rxq_eop ? 2'(len % 4) : 2'b00;
			rxq_data        = $urandom;
			n2c_exp.push_back(rxq_data);
			next_cycle();
		end
		expect_eq("rxq_full", rxq_full, (nw + 1) >= dma_pkg::FIFO_DEPTH);
		rxq_wr          = 1'b0;
		dma_op_code_req = dma_pkg::OP_TRANSF_N2C;
		dma_op_queue_id = qid;
		nf_rand_en      = 1'b1;
		wait_drained();
		nf_rand_en      = 1'b0;
		dma_op_code_req = dma_pkg::OP_IDLE;
		repeat (4) next_cycle();
	endtask

	////////////////////////////////////////
	// txq drain and scoreboard
	always @(posedge cpci_clk) begin
		#1;
		txq_rd = 1'b0;
		if (drain_en && !cpci_reset && !txq_empty) begin
			txq_rd = 1'b1;
			if (tx_exp.size() == 0) begin
				chk_errs++;
				$display("unexpected word popped from txq");
			end else begin
				expect_eq("txq_word", {txq_is_req, txq_eop, txq_valid_bytes, txq_data},
					tx_exp.pop_front());
			end
		end
	end

	// random cpci back-pressure during n2c
	always @(posedge cpci_clk) begin
		#1;
		dma_dest_q_nearly_full_c2n = nf_rand_en && ($urandom % 3 == 0);
	end

	// n2c words, sampled mid cycle
	always @(posedge cpci_clk) begin
		#50;
		if (!cpci_reset && dma_vld_n2c && dma_op_code_ack == dma_pkg::OP_TRANSF_N2C) begin
			if (n2c_exp.size() == 0) begin
				chk_errs++;
				$display("n2c word marked valid with none expected");
			end else begin
				expect_eq("dma_data_n2c", dma_data_n2c, n2c_exp.pop_front());
			end
		end
	end

	////////////////////////////////////////
	// concurrent checks
	a_n2c_backpressure: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		(dma_dest_q_nearly_full_c2n && dma_op_code_ack == dma_pkg::OP_TRANSF_N2C)
		|-> ##2 !dma_vld_n2c)
		else begin
			sva_errs++;
			$display("n2c word moved two edges after cpci nearly full");
		end

	a_nf_n2c_rise: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		(u_dut.u_tx_fifo.count >= NF_LEVEL) |=> dma_dest_q_nearly_full_n2c)
		else begin
			sva_errs++;
			$display("Error: dma_dest_q_nearly_full_n2c = 0x0, expected 0x1");
		end

	a_nf_n2c_fall: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		(u_dut.u_tx_fifo.count < NF_LEVEL) |=> !dma_dest_q_nearly_full_n2c)
		else begin
			sva_errs++;
			$display("Error: dma_dest_q_nearly_full_n2c = 0x1, expected 0x0");
		end

	// watchdog
	initial begin
		#((N_PKTS * 40 + 200) * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////
	// main sequence
	initial begin
		dma_pkg::dma_data_t d;
		logic               err;
		void'($urandom(32136));
		chk_errs = 0;
		sva_errs = 0;
		cpci_clk = 1'b0;
		cpci_reset = 1'b1;
		dma_op_code_req = dma_pkg::OP_IDLE;
		dma_op_queue_id = '0;
		dma_vld_c2n = 1'b0;
		dma_data_c2n = '0;
		dma_dest_q_nearly_full_c2n = 1'b0;
		cpu_q_dma_pkt_avail = '0;
		cpu_q_dma_nearly_full = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		txq_rd = 1'b0;
		rxq_wr = 1'b0;
		rxq_eop = 1'b0;
		rxq_valid_bytes = '0;
		rxq_data = '0;
		drain_en = 1'b1;
		nf_rand_en = 1'b0;
		repeat (2) next_cycle();
		cpci_reset = 1'b0;
		next_cycle();

		// reset values, then a request while disabled
		expect_eq("dma_op_code_ack", dma_op_code_ack, dma_pkg::OP_IDLE);
		expect_eq("dma_vld_n2c", dma_vld_n2c, 1'b0);
		expect_eq("dma_data_tri_en", dma_data_tri_en, 1'b0);
		expect_eq("dma_dest_q_nearly_full_n2c", dma_dest_q_nearly_full_n2c, 1'b0);
		expect_eq("txq_empty", txq_empty, 1'b1);
		dma_op_code_req = dma_pkg::OP_STATUS_QUERY;
		repeat (5) next_cycle();
		expect_eq("dma_op_code_ack", dma_op_code_ack, dma_pkg::OP_IDLE);
		dma_op_code_req = dma_pkg::OP_IDLE;
		repeat (2) next_cycle();

		// apb map
		apb_write(dma_pkg::REG_CTRL, 32'h1);
		check_reg(dma_pkg::REG_CTRL, 32'h1);
		apb_read(8'h0c, d, err);
		expect_eq("pslverr", err, 1'b1);

		for (int i = 0; i < N_QUERY; i++)
			run_query();

		for (int i = 0; i < N_C2N; i++) begin
			c2n_packet($urandom % 41, dma_pkg::queue_id_t'($urandom));
			check_reg(dma_pkg::REG_TX_PKTS, 32'(i + 1));
		end
		wait_drained();
		apb_write(dma_pkg::REG_TX_PKTS, 32'h0);   // write clears
		check_reg(dma_pkg::REG_TX_PKTS, 32'h0);

		// last packet fills rxq to all 16 words
		for (int i = 0; i < N_N2C; i++) begin
			n2c_packet((i == N_N2C - 1) ? 60 : int'($urandom % 41),
				dma_pkg::queue_id_t'($urandom));
			check_reg(dma_pkg::REG_RX_PKTS, 32'(i + 1));
		end
		wait_drained();

		// fill txq to 14 words without draining
		drain_en = 1'b0;
		c2n_packet(48, 4'h3);
		expect_eq("dma_dest_q_nearly_full_n2c", dma_dest_q_nearly_full_n2c, 1'b1);
		drain_en = 1'b1;
		wait_drained();
		repeat (3) next_cycle();
		expect_eq("dma_dest_q_nearly_full_n2c", dma_dest_q_nearly_full_n2c, 1'b0);
		check_reg(dma_pkg::REG_TX_PKTS, 32'h1);

		$display("check errors: %0d, assertion errors: %0d", chk_errs, sva_errs);
		if (chk_errs == 0 && sva_errs == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== dma_cpci_top.sv ====
////////////////////////////////////////
// cpci dma bridge top level
// bus fsm, apb registers, tx and rx queues
////////////////////////////////////////

`timescale 1ns/1ps

module dma_cpci_top (
	input  logic                  cpci_clk,
	input  logic                  cpci_reset,
	// cpci pins
	input  dma_pkg::dma_op_t      dma_op_code_req,
	input  dma_pkg::queue_id_t    dma_op_queue_id,
	output dma_pkg::dma_op_t      dma_op_code_ack,
	input  logic                  dma_vld_c2n,
	input  dma_pkg::dma_data_t    dma_data_c2n,
	output logic                  dma_dest_q_nearly_full_n2c,
	output logic                  dma_vld_n2c,
	output dma_pkg::dma_data_t    dma_data_n2c,
	input  logic                  dma_dest_q_nearly_full_c2n,
	output logic                  dma_data_tri_en,
	input  dma_pkg::q_mask_t      cpu_q_dma_pkt_avail,
	input  dma_pkg::q_mask_t      cpu_q_dma_nearly_full,
	// apb
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  dma_pkg::apb_addr_t    paddr,
	input  dma_pkg::dma_data_t    pwdata,
	output dma_pkg::dma_data_t    prdata,
	output logic                  pready,
	output logic                  pslverr,
	// tx queue read side, to core
	input  logic                  txq_rd,
	output logic                  txq_empty,
	output logic                  txq_is_req,
	output logic                  txq_eop,
	output dma_pkg::valid_bytes_t txq_valid_bytes,
	output dma_pkg::dma_data_t    txq_data,
	// rx queue write side, from core
	input  logic                  rxq_wr,
	input  logic                  rxq_eop,
	input  dma_pkg::valid_bytes_t rxq_valid_bytes,
	input  dma_pkg::dma_data_t    rxq_data,
	output logic                  rxq_full
);

	logic dma_enable, tx_pkt_done, rx_pkt_done;

	dma_word_if tx_q ();
	dma_word_if rx_q ();

	dma_bus_fsm u_bus_fsm (
		.cpci_clk, .cpci_reset,
		.dma_op_code_req, .dma_op_queue_id, .dma_op_code_ack,
		.dma_vld_c2n, .dma_data_c2n, .dma_dest_q_nearly_full_n2c,
		.dma_vld_n2c, .dma_data_n2c, .dma_dest_q_nearly_full_c2n,
		.dma_data_tri_en, .cpu_q_dma_pkt_avail, .cpu_q_dma_nearly_full,
		.dma_enable, .tx_pkt_done, .rx_pkt_done,
		.tx_q(tx_q), .rx_q(rx_q)
	);

	dma_regs u_regs (
		.cpci_clk, .cpci_reset,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
		.tx_pkt_done, .rx_pkt_done, .dma_enable
	);

	dma_word_fifo u_tx_fifo (.cpci_clk, .cpci_reset, .q(tx_q));
	dma_word_fifo u_rx_fifo (.cpci_clk, .cpci_reset, .q(rx_q));

	// tx queue fields out to the core
	assign tx_q.rd         = txq_rd;
	assign txq_empty       = tx_q.empty;
	assign txq_is_req      = tx_q.rd_word[dma_pkg::WORD_IS_REQ];
	assign txq_eop         = tx_q.rd_word[dma_pkg::WORD_EOP];
	assign txq_valid_bytes = tx_q.rd_word[dma_pkg::WORD_VB_LSB +: 2];
	assign txq_data        = tx_q.rd_word[dma_pkg::WORD_DATA_LSB +: dma_pkg::DMA_DATA_WIDTH];

	// rx words from the core never carry a request
	assign rx_q.wr      = rxq_wr;
	assign rx_q.wr_word = dma_pkg::mk_word(1'b0, rxq_eop, rxq_valid_bytes, rxq_data);
	assign rxq_full     = rx_q.full;

endmodule

// ==== dma_regs.sv ====
////////////////////////////////////////
// apb register block
// dma enable and c2n/n2c packet counters
////////////////////////////////////////

`timescale 1ns/1ps

module dma_regs (
	input  logic                cpci_clk,
	input  logic                cpci_reset,
	// apb slave
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  dma_pkg::apb_addr_t  paddr,
	input  dma_pkg::dma_data_t  pwdata,
	output dma_pkg::dma_data_t  prdata,
	output logic                pready,
	output logic                pslverr,
	// fsm side
	input  logic                tx_pkt_done,
	input  logic                rx_pkt_done,
	output logic                dma_enable
);

	dma_pkg::dma_data_t tx_pkts;
	dma_pkg::dma_data_t rx_pkts;
	logic               access;     // apb access phase
	logic               wr_access;
	logic               addr_hit;

	assign access    = psel && penable;
	assign wr_access = access && pwrite;
	assign addr_hit  = paddr inside {dma_pkg::REG_CTRL, dma_pkg::REG_TX_PKTS,
		dma_pkg::REG_RX_PKTS};

	assign pready  = 1'b1;   // no wait states
	assign pslverr = access && !addr_hit;

	// count up, stick at all ones
	function automatic dma_pkg::dma_data_t sat_inc(input dma_pkg::dma_data_t v);
		return (v == '1) ? v : v + 1'b1;
	endfunction

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			dma_enable <= 1'b0;
			tx_pkts    <= '0;
			rx_pkts    <= '0;
		end else begin
			if (wr_access && paddr == dma_pkg::REG_CTRL)
				dma_enable <= pwdata[0];
			if (wr_access && paddr == dma_pkg::REG_TX_PKTS)
				tx_pkts <= '0;              // clear wins over a count
			else if (tx_pkt_done)
				tx_pkts <= sat_inc(tx_pkts);
			if (wr_access && paddr == dma_pkg::REG_RX_PKTS)
				rx_pkts <= '0;
			else if (rx_pkt_done)
				rx_pkts <= sat_inc(rx_pkts);
		end
	end

	// read mux
	always_comb begin
		case (paddr)
			dma_pkg::REG_CTRL:    prdata = dma_pkg::dma_data_t'(dma_enable);
			dma_pkg::REG_TX_PKTS: prdata = tx_pkts;
			dma_pkg::REG_RX_PKTS: prdata = rx_pkts;
			default:              prdata = '0;
		endcase
	end

	// an access phase always follows a setup phase
	a_penable_after_psel: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		penable |-> $past(psel));

endmodule

// ==== dma_bus_fsm.sv ====
////////////////////////////////////////
// cpci dma bus state machine
// status query, c2n and n2c transfers
////////////////////////////////////////

`timescale 1ns/1ps

module dma_bus_fsm (
	input  logic                 cpci_clk,
	input  logic                 cpci_reset,
	// cpci pins
	input  dma_pkg::dma_op_t     dma_op_code_req,
	input  dma_pkg::queue_id_t   dma_op_queue_id,
	output dma_pkg::dma_op_t     dma_op_code_ack,
	input  logic                 dma_vld_c2n,
	input  dma_pkg::dma_data_t   dma_data_c2n,
	output logic                 dma_dest_q_nearly_full_n2c,
	output logic                 dma_vld_n2c,
	output dma_pkg::dma_data_t   dma_data_n2c,
	input  logic                 dma_dest_q_nearly_full_c2n,
	output logic                 dma_data_tri_en,
	// core side
	input  dma_pkg::q_mask_t     cpu_q_dma_pkt_avail,
	input  dma_pkg::q_mask_t     cpu_q_dma_nearly_full,
	input  logic                 dma_enable,
	output logic                 tx_pkt_done,
	output logic                 rx_pkt_done,
	dma_word_if.writer           tx_q,
	dma_word_if.reader           rx_q
);

	// registered cpci inputs
	dma_pkg::dma_op_t   op_req_d;
	dma_pkg::queue_id_t qid_d;
	logic               vld_c2n_d;
	dma_pkg::dma_data_t data_c2n_d;
	logic               nf_c2n_d;

	dma_pkg::dma_state_t state, state_nxt;
	dma_pkg::dma_op_t    ack_nxt;
	logic                vld_nxt, tri_en_nxt;
	dma_pkg::dma_data_t  data_nxt;
	dma_pkg::pkt_len_t   tx_len, tx_len_nxt;   // c2n bytes left
	dma_pkg::pkt_len_t   rx_len, rx_len_nxt;   // n2c bytes left
	logic                tx_done_nxt, rx_done_nxt;
	logic                rx_go;                // an n2c word can move

	always_ff @(posedge cpci_clk) begin
		qid_d      <= dma_op_queue_id;
		data_c2n_d <= dma_data_c2n;
	end

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			op_req_d  <= dma_pkg::OP_IDLE;
			vld_c2n_d <= 1'b0;
			nf_c2n_d  <= 1'b0;
		end else begin
			op_req_d  <= dma_op_code_req;
			vld_c2n_d <= dma_vld_c2n;
			nf_c2n_d  <= dma_dest_q_nearly_full_c2n;
		end
	end

	assign rx_go = !rx_q.empty && !nf_c2n_d;

	// state picked by a new op code
	function automatic dma_pkg::dma_state_t op_state(input dma_pkg::dma_op_t op);
		case (op)
			dma_pkg::OP_STATUS_QUERY: return dma_pkg::ST_QUERY;
			dma_pkg::OP_TRANSF_C2N:   return dma_pkg::ST_C2N_QID;
			dma_pkg::OP_TRANSF_N2C:   return dma_pkg::ST_N2C_QID;
			default:                  return dma_pkg::ST_IDLE;
		endcase
	endfunction

	////////////////////////////////////////
	// next state and output decode
	always_comb begin
		dma_pkg::dma_data_t status;
		status = '0;
		status[dma_pkg::STATUS_AVAIL_LSB +: dma_pkg::NUM_CPU_QUEUES] = cpu_q_dma_pkt_avail;
		status[dma_pkg::NUM_CPU_QUEUES-1:0] = cpu_q_dma_nearly_full;

		state_nxt   = state;
		ack_nxt     = dma_op_code_ack;   // ack and tri_en hold
		tri_en_nxt  = dma_data_tri_en;
		vld_nxt     = 1'b0;              // vld only on words that move
		data_nxt    = '0;
		tx_len_nxt  = tx_len;
		rx_len_nxt  = rx_len;
		tx_done_nxt = 1'b0;
		rx_done_nxt = 1'b0;
		tx_q.wr      = 1'b0;
		tx_q.wr_word = '0;
		rx_q.rd      = 1'b0;

		case (state)
			dma_pkg::ST_IDLE: begin
				ack_nxt    = dma_pkg::OP_IDLE;
				tri_en_nxt = 1'b0;
				if (dma_enable)
					state_nxt = op_state(op_req_d);
			end
			dma_pkg::ST_QUERY: begin
				ack_nxt    = dma_pkg::OP_STATUS_QUERY;
				tri_en_nxt = 1'b1;
				vld_nxt    = 1'b1;
				data_nxt   = status;   // refreshed every cycle
				if (op_req_d != dma_pkg::OP_STATUS_QUERY)
					state_nxt = op_state(op_req_d);
			end
			dma_pkg::ST_C2N_QID: begin
				ack_nxt      = dma_pkg::OP_TRANSF_C2N;
				tri_en_nxt   = 1'b0;
				tx_q.wr      = 1'b1;   // request word, direction 0
				tx_q.wr_word = dma_pkg::mk_word(1'b1, 1'b0, '0, dma_pkg::dma_data_t'(qid_d));
				state_nxt    = dma_pkg::ST_C2N_LEN;
			end
			dma_pkg::ST_C2N_LEN: begin
				if (vld_c2n_d) begin
					tx_len_nxt   = data_c2n_d[dma_pkg::PKT_LEN_CNT_WIDTH-1:0];
					tx_q.wr      = 1'b1;
					tx_q.wr_word = dma_pkg::mk_word(1'b0, tx_len_nxt == '0, '0, data_c2n_d);
					if (tx_len_nxt == '0) begin   // empty packet ends here
						tx_done_nxt = 1'b1;
						state_nxt   = dma_pkg::ST_C2N_DONE;
					end else begin
						state_nxt = dma_pkg::ST_C2N_DATA;
					end
				end
			end
			dma_pkg::ST_C2N_DATA: begin
				if (vld_c2n_d) begin
					tx_q.wr = 1'b1;
					if (tx_len <= dma_pkg::pkt_len_t'(dma_pkg::BYTES_PER_WORD)) begin
						tx_q.wr_word = dma_pkg::mk_word(1'b0, 1'b1, tx_len[1:0], data_c2n_d);
						tx_len_nxt   = '0;
						tx_done_nxt  = 1'b1;
						state_nxt    = dma_pkg::ST_C2N_DONE;
					end else begin
						tx_q.wr_word = dma_pkg::mk_word(1'b0, 1'b0, '0, data_c2n_d);
						tx_len_nxt   = dma_pkg::pkt_len_t'(tx_len - dma_pkg::BYTES_PER_WORD);
					end
				end
			end
			dma_pkg::ST_C2N_DONE: begin
				if (op_req_d != dma_pkg::OP_TRANSF_C2N)
					state_nxt = op_state(op_req_d);
			end
			dma_pkg::ST_N2C_QID: begin
				ack_nxt      = dma_pkg::OP_TRANSF_N2C;
				tri_en_nxt   = 1'b1;
				tx_q.wr      = 1'b1;   // request word, direction 1
				tx_q.wr_word = dma_pkg::mk_word(1'b1, 1'b1, '0, dma_pkg::dma_data_t'(qid_d));
				rx_len_nxt   = '0;
				state_nxt    = dma_pkg::ST_N2C_LEN;
			end
			dma_pkg::ST_N2C_LEN: begin
				if (rx_go) begin
					rx_q.rd    = 1'b1;
					vld_nxt    = 1'b1;
					data_nxt   = rx_q.rd_word[dma_pkg::WORD_DATA_LSB +: dma_pkg::DMA_DATA_WIDTH];
					rx_len_nxt = data_nxt[dma_pkg::PKT_LEN_CNT_WIDTH-1:0];
					if (rx_len_nxt == '0) begin
						rx_done_nxt = 1'b1;
						state_nxt   = dma_pkg::ST_N2C_DONE;
					end else begin
						state_nxt = dma_pkg::ST_N2C_DATA;
					end
				end
			end
			dma_pkg::ST_N2C_DATA: begin
				if (rx_go) begin
					rx_q.rd  = 1'b1;
					vld_nxt  = 1'b1;
					data_nxt = rx_q.rd_word[dma_pkg::WORD_DATA_LSB +: dma_pkg::DMA_DATA_WIDTH];
					if (rx_len <= dma_pkg::pkt_len_t'(dma_pkg::BYTES_PER_WORD)) begin
						rx_len_nxt  = '0;
						rx_done_nxt = 1'b1;
						state_nxt   = dma_pkg::ST_N2C_DONE;
					end else begin
						rx_len_nxt = dma_pkg::pkt_len_t'(rx_len - dma_pkg::BYTES_PER_WORD);
					end
				end
			end
			dma_pkg::ST_N2C_DONE: begin
				if (op_req_d != dma_pkg::OP_TRANSF_N2C)
					state_nxt = op_state(op_req_d);
			end
			default: state_nxt = dma_pkg::ST_IDLE;
		endcase
	end

	////////////////////////////////////////
	// registered outputs
	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			state                      <= dma_pkg::ST_IDLE;
			dma_op_code_ack            <= dma_pkg::OP_IDLE;
			dma_vld_n2c                <= 1'b0;
			dma_data_tri_en            <= 1'b0;
			dma_dest_q_nearly_full_n2c <= 1'b0;
			tx_len                     <= '0;
			rx_len                     <= '0;
			tx_pkt_done                <= 1'b0;
			rx_pkt_done                <= 1'b0;
		end else begin
			state                      <= state_nxt;
			dma_op_code_ack            <= ack_nxt;
			dma_vld_n2c                <= vld_nxt;
			dma_data_tri_en            <= tri_en_nxt;
			dma_dest_q_nearly_full_n2c <= tx_q.nearly_full;   // one edge behind the queue
			tx_len                     <= tx_len_nxt;
			rx_len                     <= rx_len_nxt;
			tx_pkt_done                <= tx_done_nxt;
			rx_pkt_done                <= rx_done_nxt;
		end
	end

	always_ff @(posedge cpci_clk)
		dma_data_n2c <= data_nxt;

	// data is only marked valid while the bridge drives the bus
	a_vld_tri_en: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		dma_vld_n2c |-> dma_data_tri_en);

	// cpci is expected to stop on nearly_full_n2c
	a_tx_not_full: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		tx_q.wr |-> !tx_q.full);

endmodule

// ==== dma_word_fifo.sv ====
////////////////////////////////////////
// first-word-fall-through word queue
// 16 entries, full/nearly-full/empty flags
////////////////////////////////////////

`timescale 1ns/1ps

module dma_word_fifo (
	input logic        cpci_clk,
	input logic        cpci_reset,
	dma_word_if.queue  q
);

	dma_pkg::dma_word_t mem [dma_pkg::FIFO_DEPTH];

	logic [dma_pkg::FIFO_ADDR_WIDTH-1:0] wr_ptr;
	logic [dma_pkg::FIFO_ADDR_WIDTH-1:0] rd_ptr;
	logic [dma_pkg::FIFO_ADDR_WIDTH:0]   count;    // one extra bit to tell full from empty
	logic                                do_wr;
	logic                                do_rd;

	assign do_wr = q.wr && !q.full;
	assign do_rd = q.rd && !q.empty;

	// storage
	always_ff @(posedge cpci_clk) begin
		if (do_wr)
			mem[wr_ptr] <= q.wr_word;
	end

	// pointers and occupancy
	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // idle or simultaneous
			endcase
		end
	end

	assign q.rd_word     = mem[rd_ptr];   // head word, valid when !empty
	assign q.empty       = (count == '0);
	assign q.full        = (count == ($bits(count))'(dma_pkg::FIFO_DEPTH));
	assign q.nearly_full = (count >= ($bits(count))'(dma_pkg::FIFO_DEPTH -
		dma_pkg::FIFO_NEARLY_FULL_MARGIN));

	////////////////////////////////////////
	// writer and reader must honor the flags
	a_no_wr_full: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		q.wr |-> !q.full);

	a_no_rd_empty: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		q.rd |-> !q.empty);

endmodule

// ==== dma_word_if.sv ====
////////////////////////////////////////
// word queue interface
// write side, read side and status flags
////////////////////////////////////////

`timescale 1ns/1ps

interface dma_word_if;

	// write side
	logic               wr;
	dma_pkg::dma_word_t wr_word;
	logic               full;
	logic               nearly_full;   // at most two entries free

	// read side, head word shown while not empty
	logic               rd;
	dma_pkg::dma_word_t rd_word;
	logic               empty;

	modport writer (
		output wr, wr_word,
		input  full, nearly_full
	);

	modport reader (
		output rd,
		input  rd_word, empty
	);

	modport queue (
		input  wr, wr_word, rd,
		output full, nearly_full, rd_word, empty
	);

endinterface

// ==== dma_pkg.sv ====
////////////////////////////////////////
// shared definitions for the cpci dma bridge
// widths, vector types, op and state enums
// queued word layout and apb register map
////////////////////////////////////////

package dma_pkg;

	// cpci protocol widths
	localparam int DMA_DATA_WIDTH    = 32;
	localparam int NUM_CPU_QUEUES    = 4;
	localparam int PKT_LEN_CNT_WIDTH = 11;
	localparam int QUEUE_ID_WIDTH    = 4;
	localparam int BYTES_PER_WORD    = DMA_DATA_WIDTH / 8;
	localparam int STATUS_AVAIL_LSB  = 16;   // pkt_avail position in the status word

	typedef logic [DMA_DATA_WIDTH-1:0]    dma_data_t;
	typedef logic [QUEUE_ID_WIDTH-1:0]    queue_id_t;
	typedef logic [PKT_LEN_CNT_WIDTH-1:0] pkt_len_t;
	typedef logic [1:0]                   valid_bytes_t;   // 0 means all 4
	typedef logic [NUM_CPU_QUEUES-1:0]    q_mask_t;
	typedef logic [DMA_DATA_WIDTH+3:0]    dma_word_t;      // {is_req, eop, vb, data}

	// queued word layout
	localparam int WORD_IS_REQ   = 35;
	localparam int WORD_EOP      = 34;   // direction in a request word, 1 = n2c
	localparam int WORD_VB_LSB   = 32;
	localparam int WORD_DATA_LSB = 0;

	// word queue sizing
	localparam int FIFO_ADDR_WIDTH         = 4;
	localparam int FIFO_DEPTH              = 1 << FIFO_ADDR_WIDTH;
	localparam int FIFO_NEARLY_FULL_MARGIN = 2;   // free entries left when flagged

	typedef enum logic [1:0] {
		OP_IDLE         = 2'b00,
		OP_STATUS_QUERY = 2'b01,
		OP_TRANSF_C2N   = 2'b10,
		OP_TRANSF_N2C   = 2'b11
	} dma_op_t;

	typedef enum logic [3:0] {
		ST_IDLE, ST_QUERY,
		ST_C2N_QID, ST_C2N_LEN, ST_C2N_DATA, ST_C2N_DONE,
		ST_N2C_QID, ST_N2C_LEN, ST_N2C_DATA, ST_N2C_DONE
	} dma_state_t;

	////////////////////////////////////////
	// apb register map
	localparam int APB_ADDR_WIDTH = 8;
	typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
	localparam apb_addr_t REG_CTRL    = 8'h00;   // bit 0 dma enable
	localparam apb_addr_t REG_TX_PKTS = 8'h04;   // c2n packets, write clears
	localparam apb_addr_t REG_RX_PKTS = 8'h08;   // n2c packets, write clears

	// build a queued word from its fields
	function automatic dma_word_t mk_word(input logic is_req, input logic eop,
		input valid_bytes_t vb, input dma_data_t data);
		return {is_req, eop, vb, data};
	endfunction

endpackage
